// ==== hw/rt_regs_pkg.sv ====
package rt_regs_pkg;

    parameter int data_w           = 32;
    parameter int addr_w           = 8;
    parameter int char_w           = 8;
    parameter int nibble_w         = 4;
    parameter int nibbles_per_word = data_w / nibble_w;

    // Host register map, byte addresses
    parameter logic [addr_w-1:0] addr_control       = 8'h00;
    parameter logic [addr_w-1:0] addr_itrng_divisor = 8'h04;
    parameter logic [addr_w-1:0] addr_itrng_data    = 8'h08;
    parameter logic [addr_w-1:0] addr_itrng_status  = 8'h0C;
    parameter logic [addr_w-1:0] addr_log_data      = 8'h10;
    parameter logic [addr_w-1:0] addr_log_status    = 8'h14;
    parameter logic [addr_w-1:0] addr_cycle_count   = 8'h18;

    parameter int itrng_flush_bit = 2;  // Write-one flush in entropy status

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic              valid;  // Bit 8 of log data
        logic [char_w-1:0] ch;
    } log_char_t;

    typedef struct packed {
        logic control;
        logic itrng_divisor;
        logic itrng_data;
        logic itrng_status;
        logic log_data;
        logic log_status;
        logic cycle_count;
    } reg_sel_t;

    // Packed order matches the status register, full in bit 1
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

    // Written by the host as one word, drained by the core nibble by nibble
    typedef union packed {
        logic [data_w-1:0]                             raw;
        logic [nibbles_per_word-1:0][nibble_w-1:0]     nib;
    } entropy_word_u;

endpackage

// ==== hw/reg_decode.sv ====
`timescale 1ns/1ps

module reg_decode import rt_regs_pkg::*; (
    input  logic              core_clk,
    input  logic              hwif_out,
    input  host_req_t         host_req,
    output reg_sel_t          reg_sel,
    output logic              log_pop,
    output logic              itrng_push,
    output entropy_word_u     itrng_word,
    output logic              itrng_flush,
    output logic [data_w-1:0] divisor,
    output logic              core_rst_b
);

    reg_sel_t sel;
    logic     wr_control;
    logic     wr_divisor;

    // Single address compare shared by reads and writes
    always_comb begin
        sel = '0;
        case (host_req.addr)
            addr_control:       sel.control       = 1'b1;
            addr_itrng_divisor: sel.itrng_divisor = 1'b1;
            addr_itrng_data:    sel.itrng_data    = 1'b1;
            addr_itrng_status:  sel.itrng_status  = 1'b1;
            addr_log_data:      sel.log_data      = 1'b1;
            addr_log_status:    sel.log_status    = 1'b1;
            addr_cycle_count:   sel.cycle_count   = 1'b1;
            default:            sel               = '0;  // Unmapped, reads as 0
        endcase
    end

    assign reg_sel = sel;  // Qualified by host_req.rd downstream

    assign wr_control = host_req.wr & sel.control;
    assign wr_divisor = host_req.wr & sel.itrng_divisor;

    // Pop happens at the read edge, readback samples the old head
    assign log_pop = host_req.rd & sel.log_data;

    assign itrng_push     = host_req.wr & sel.itrng_data;
    assign itrng_word.raw = host_req.wdata;
    assign itrng_flush    = host_req.wr & sel.itrng_status & host_req.wdata[itrng_flush_bit];

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            core_rst_b <= 1'b0;  // Core held in reset until software releases it
        end else if (wr_control) begin
            core_rst_b <= host_req.wdata[0];
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor <= '0;
        end else if (wr_divisor) begin
            divisor <= host_req.wdata;
        end
    end

endmodule

// ==== hw/log_fifo.sv ====
`timescale 1ns/1ps

module log_fifo import rt_regs_pkg::*; #(
    parameter int depth = 16
) (
    input  logic              core_clk,
    input  logic              hwif_out,
    input  log_char_t         log_char,
    input  logic              log_pop,
    output logic [char_w-1:0] head,
    output fifo_status_t      status
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [char_w-1:0] mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              push;
    logic              pop;

    assign status.empty = (count == '0);
    assign status.full  = (count == cnt_w'(depth));

    assign push = log_char.valid & ~status.full;  // Characters dropped while full
    assign pop  = log_pop & ~status.empty;

    assign head = mem[rd_ptr];  // Fall-through view of the oldest entry

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= log_char.ch;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

// ==== hw/entropy_fifo.sv ====
`timescale 1ns/1ps

module entropy_fifo import rt_regs_pkg::*; #(
    parameter int depth = 4
) (
    input  logic                core_clk,
    input  logic                hwif_out,
    input  logic                itrng_push,
    input  entropy_word_u       itrng_word,
    input  logic                itrng_flush,
    input  logic [data_w-1:0]   divisor,
    input  logic                etrng_req,
    output logic [nibble_w-1:0] itrng_data,
    output logic                itrng_valid,
    output fifo_status_t        status
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam int idx_w = $clog2(nibbles_per_word);

    entropy_word_u     mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic [idx_w-1:0]  nib_idx;  // Next nibble of the head word
    logic [data_w-1:0] throttle;
    logic              grant;
    logic              push;
    logic              send;
    logic              pop;

    assign status.empty = (count == '0);
    assign status.full  = (count == cnt_w'(depth));

    assign push = itrng_push & ~status.full & ~itrng_flush;
    assign send = grant & ~status.empty & ~itrng_flush;
    assign pop  = send & (nib_idx == idx_w'(nibbles_per_word - 1));  // Last nibble out

    // Request throttle, grants spaced by divisor+1 cycles at least
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle <= '0;
            grant    <= 1'b0;
        end else if (throttle == '0) begin
            grant    <= etrng_req;
            throttle <= divisor;
        end else begin
            grant    <= 1'b0;
            throttle <= throttle - 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= itrng_word;
        end
        if (send) begin
            itrng_data <= mem[rd_ptr].nib[nib_idx];  // Lowest nibble first
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= send;
            if (itrng_flush) begin
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                count   <= '0;
                nib_idx <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
                end
                if (send) begin
                    nib_idx <= nib_idx + 1'b1;  // Wraps to 0 with the pop
                end
                count <= count + cnt_w'(push) - cnt_w'(pop);
            end
        end
    end

endmodule

// ==== hw/reg_readback.sv ====
`timescale 1ns/1ps

module reg_readback import rt_regs_pkg::*; (
    input  logic              core_clk,
    input  logic              hwif_out,
    input  logic              host_rd,
    input  reg_sel_t          reg_sel,
    input  logic              core_rst_b,
    input  logic [data_w-1:0] divisor,
    input  logic [char_w-1:0] log_head,
    input  fifo_status_t      log_status,
    input  fifo_status_t      itrng_status,
    output host_rsp_t         host_rsp
);

    logic [data_w-1:0] cycle_count;
    logic [data_w-1:0] rd_mux;
    log_char_t         log_word;
    logic              rsp_valid;
    logic [data_w-1:0] rsp_rdata;

    // Free-running while the core is out of reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!core_rst_b) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    assign log_word.valid = ~log_status.empty;
    assign log_word.ch    = log_head;

    always_comb begin
        rd_mux = '0;
        if (reg_sel.control)            rd_mux = data_w'(core_rst_b);
        else if (reg_sel.itrng_divisor) rd_mux = divisor;
        else if (reg_sel.itrng_status)  rd_mux = data_w'(itrng_status);
        else if (reg_sel.log_data)      rd_mux = data_w'(log_word);
        else if (reg_sel.log_status)    rd_mux = data_w'(log_status);
        else if (reg_sel.cycle_count)   rd_mux = cycle_count;
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) rsp_valid <= 1'b0;
        else           rsp_valid <= host_rd;
    end

    always_ff @(posedge core_clk) begin
        rsp_rdata <= rd_mux;
    end

    assign host_rsp.valid = rsp_valid;
    assign host_rsp.rdata = rsp_rdata;

endmodule

// ==== hw/realtime_top.sv ====
`timescale 1ns/1ps

module realtime_top import rt_regs_pkg::*; #(
    parameter int log_depth     = 16,
    parameter int entropy_depth = 4
) (
    input  logic                core_clk,
    input  logic                hwif_out,
    input  host_req_t           host_req,
    output host_rsp_t           host_rsp,
    input  log_char_t           log_char,
    input  logic                etrng_req,
    output logic [nibble_w-1:0] itrng_data,
    output logic                itrng_valid
);

    reg_sel_t          reg_sel;
    logic              log_pop;
    logic              itrng_push;
    entropy_word_u     itrng_word;
    logic              itrng_flush;
    logic [data_w-1:0] divisor;
    logic              core_rst_b;
    logic [char_w-1:0] log_head;
    fifo_status_t      log_status;
    fifo_status_t      itrng_status;

    reg_decode u_decode (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .host_req    (host_req),
        .reg_sel     (reg_sel),
        .log_pop     (log_pop),
        .itrng_push  (itrng_push),
        .itrng_word  (itrng_word),
        .itrng_flush (itrng_flush),
        .divisor     (divisor),
        .core_rst_b  (core_rst_b)
    );

    log_fifo #(.depth(log_depth)) u_log_fifo (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .log_char (log_char),
        .log_pop  (log_pop),
        .head     (log_head),
        .status   (log_status)
    );

    entropy_fifo #(.depth(entropy_depth)) u_entropy_fifo (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .itrng_push  (itrng_push),
        .itrng_word  (itrng_word),
        .itrng_flush (itrng_flush),
        .divisor     (divisor),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .status      (itrng_status)
    );

    reg_readback u_readback (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .host_rd      (host_req.rd),
        .reg_sel      (reg_sel),
        .core_rst_b   (core_rst_b),
        .divisor      (divisor),
        .log_head     (log_head),
        .log_status   (log_status),
        .itrng_status (itrng_status),
        .host_rsp     (host_rsp)
    );

endmodule

// ==== include/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

localparam int bus_timeout = 16;  // Cycles allowed for a read response

logic [31:0] lfsr_state = 32'h54993f33;

// Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge core_clk);
    #1;
    host_req.wr    = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = data;
    @(posedge core_clk);
    #1;
    host_req.wr = 1'b0;
endtask

task automatic host_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    int waited;
    @(posedge core_clk);
    #1;
    host_req.rd   = 1'b1;
    host_req.addr = addr;
    @(posedge core_clk);
    #1;
    read_edge   = edge_count;  // Edge that took the strobe
    host_req.rd = 1'b0;
    waited      = 0;
    while (!host_rsp.valid && waited < bus_timeout) begin
        @(posedge core_clk);
        #1;
        waited++;
    end
    if (!host_rsp.valid) report_fault("Timed out waiting for a host read response");
    else data = host_rsp.rdata;
endtask

`endif

// ==== test/tb_realtime_top.sv ====
`timescale 1ns/1ps

module tb_realtime_top import rt_regs_pkg::*; ();

    localparam int log_depth     = 16;
    localparam int entropy_depth = 4;
    localparam int word_count    = 3;
    localparam int drain_limit   = 400;

    logic                core_clk;
    logic                hwif_out;
    host_req_t           host_req;
    host_rsp_t           host_rsp;
    log_char_t           log_char;
    logic                etrng_req;
    logic [nibble_w-1:0] itrng_data;
    logic                itrng_valid;

    int                  edge_count = 0;
    int                  read_edge;
    int                  cur_div;
    int                  pulse_gap = 1000;  // Large until the first pulse
    logic [nibble_w-1:0] exp_nib [$];

    `include "tb_util.svh"

    realtime_top #(.log_depth(log_depth), .entropy_depth(entropy_depth)) UUT (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .log_char    (log_char),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    always @(posedge core_clk) edge_count <= edge_count + 1;

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic value_mismatch(input string test, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("[FAIL] %s expected %h actual %h", test, exp, act);
        abort_run();
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic expect_read(input string test, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] exp);
        logic [data_w-1:0] act;
        host_read(addr, act);
        assert (act == exp) else value_mismatch(test, exp, act);
    endtask

    task automatic push_char(input logic [char_w-1:0] ch);
        @(posedge core_clk);
        #1;
        log_char.valid = 1'b1;
        log_char.ch    = ch;
        @(posedge core_clk);
        #1;
        log_char.valid = 1'b0;
    endtask

    // Read latency is exactly one cycle
    assert property (@(posedge core_clk) disable iff (!hwif_out) host_req.rd |=> host_rsp.valid)
        else report_fault("Read response missing one cycle after its strobe");
    assert property (@(posedge core_clk) disable iff (!hwif_out) !host_req.rd |=> !host_rsp.valid)
        else report_fault("Read response valid without a read strobe");

    // Entropy scoreboard, order and grant spacing
    always @(posedge core_clk) begin
        pulse_gap = pulse_gap + 1;
        if (hwif_out && itrng_valid) begin
            if (exp_nib.size() == 0) begin
                report_fault("itrng_valid pulsed with no entropy nibble pending");
            end else begin
                assert (itrng_data == exp_nib[0])
                    else value_mismatch("entropy_order", 32'(exp_nib[0]), 32'(itrng_data));
                assert (pulse_gap >= cur_div + 1)
                    else value_mismatch("entropy_throttle", cur_div + 1, pulse_gap);
                void'(exp_nib.pop_front());
                pulse_gap = 0;
            end
        end
    end

    initial begin
        logic [data_w-1:0] rdata;
        logic [data_w-1:0] word;
        logic [char_w-1:0] chars [log_depth+1];
        int                t0;
        int                waited;
        int                drained;

        hwif_out  = 1'b0;
        host_req  = '0;
        log_char  = '0;
        etrng_req = 1'b0;
        cur_div   = 0;
        repeat (3) @(posedge core_clk);
        #1;
        hwif_out = 1'b1;

        expect_read("reset_control", addr_control, 32'h0);
        expect_read("reset_cycle_count", addr_cycle_count, 32'h0);  // Core still held
        expect_read("unmapped_read", 8'h3C, 32'h0);

        host_write(addr_itrng_divisor, 32'h3);
        cur_div = 3;
        expect_read("divisor_readback", addr_itrng_divisor, 32'h3);
        host_write(addr_control, 32'h1);
        expect_read("control_readback", addr_control, 32'h1);
        host_read(addr_cycle_count, word);
        t0 = read_edge;
        repeat (5) @(posedge core_clk);
        host_read(addr_cycle_count, rdata);
        assert (rdata - word == 32'(read_edge - t0))
            else value_mismatch("cycle_count_delta", read_edge - t0, rdata - word);

        // Log order, then an empty read must not eat the next character
        for (int i = 0; i < 6; i++) begin
            chars[i] = char_w'(rand_bits(char_w));
            push_char(chars[i]);
        end
        for (int i = 0; i < 6; i++) begin
            expect_read("log_order", addr_log_data, {23'h0, 1'b1, chars[i]});
        end
        host_read(addr_log_data, rdata);
        assert (rdata[8] == 1'b0) else value_mismatch("log_empty_valid", 32'h0, 32'(rdata[8]));
        chars[0] = char_w'(rand_bits(char_w));
        push_char(chars[0]);
        expect_read("log_after_empty", addr_log_data, {23'h0, 1'b1, chars[0]});

        // One push beyond depth is dropped
        for (int i = 0; i <= log_depth; i++) begin
            chars[i] = char_w'(rand_bits(char_w));
            push_char(chars[i]);
        end
        expect_read("log_full_status", addr_log_status, 32'h2);
        drained = 0;
        host_read(addr_log_data, rdata);
        while (rdata[8] && drained <= log_depth) begin
            assert (rdata == {23'h0, 1'b1, chars[drained]})
                else value_mismatch("log_full_order", {23'h0, 1'b1, chars[drained]}, rdata);
            drained++;
            host_read(addr_log_data, rdata);
        end
        assert (drained == log_depth) else value_mismatch("log_drop_count", log_depth, drained);

        etrng_req = 1'b1;
        for (int w = 0; w < word_count; w++) begin
            word = rand_bits(data_w);
            for (int n = 0; n < data_w / nibble_w; n++) begin
                exp_nib.push_back(word[n*nibble_w +: nibble_w]);  // Lowest nibble first
            end
            host_write(addr_itrng_data, word);
        end
        waited = 0;
        while (exp_nib.size() > 0 && waited < drain_limit) begin
            @(posedge core_clk);
            #1;
            waited++;
        end
        if (exp_nib.size() > 0) report_fault("Timed out waiting for entropy nibbles");
        else expect_read("itrng_drained", addr_itrng_status, 32'h1);

        // Queue two words with no request, flush, then request again
        etrng_req = 1'b0;
        repeat (cur_div + 2) @(posedge core_clk);
        host_write(addr_itrng_data, rand_bits(data_w));
        host_write(addr_itrng_data, rand_bits(data_w));
        expect_read("itrng_loaded", addr_itrng_status, 32'h0);
        host_write(addr_itrng_status, 32'h4);
        expect_read("itrng_flush_status", addr_itrng_status, 32'h1);
        etrng_req = 1'b1;
        repeat (50) @(posedge core_clk);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hw/rt_regs_pkg.sv
hw/reg_decode.sv
hw/log_fifo.sv
hw/entropy_fifo.sv
hw/reg_readback.sv
hw/realtime_top.sv
test/tb_realtime_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then judge the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_realtime_top \
    -f files.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "Verification failed" sim.log && { cat sim.log; exit 1; }
grep -q "Verification passed" sim.log && { cat sim.log; exit 0; }
echo "No result found in sim.log" && exit 1
